// File: rtl/vpuInstrPkg.sv
// instruction format package: host opcodes, field types and field positions.
`default_nettype none

package vpuInstrPkg;

	////////////////////////////////////////
	// instruction word
	////////////////////////////////////////

	typedef logic [31:0] instrWordT;         // one host word, dataA or dataB.

	typedef logic [4:0] spriteIdxT;          // sprite register index.

	// opcode lives in the two low bits of dataA.
	typedef enum logic [1:0] {
		opSetPosition = 2'd0,                // x and y into a sprite register.
		opWriteMemory = 2'd1,                // colour into sprite memory.
		opSetOffset   = 2'd2,                // memory offset of a sprite.
		opReadStatus  = 2'd3                 // status word back to host.
	} opcodeT;

	////////////////////////////////////////
	// field positions in dataA
	////////////////////////////////////////

	localparam int opcodeLsb    = 0;         // opcode bits 1..0.
	localparam int spriteIdxLsb = 4;         // sprite index bits 8..4.
	localparam int memAddrLsb   = 4;         // memory address starts at bit 4.

	////////////////////////////////////////
	// execution control states
	////////////////////////////////////////

	// idle waits for a decoded instruction, settle keeps busy up one more cycle
	typedef enum logic {
		ctrlIdle   = 1'b0,                   // ready for work.
		ctrlSettle = 1'b1                    // post-execute gap.
	} ctrlStateT;

endpackage

`default_nettype wire

// File: rtl/vpuSpritePkg.sv
// sprite state package: coordinate, offset, colour and status word types.
`default_nettype none

package vpuSpritePkg;

	////////////////////////////////////////
	// sprite state types
	////////////////////////////////////////

	typedef logic [9:0]  coordT;             // screen coordinate.
	typedef logic [8:0]  offsetT;            // sprite memory offset.
	typedef logic [8:0]  colorT;             // 3 bits each of r, g, b.
	typedef logic [31:0] statusT;            // status word to host.

	////////////////////////////////////////
	// operand (dataB) layout
	////////////////////////////////////////

	localparam int coordXLsb = 0;            // x in bits 9..0.
	localparam int coordYLsb = 10;           // y in bits 19..10.

	////////////////////////////////////////
	// status word layout
	////////////////////////////////////////

	localparam int statusIdleBit   = 0;      // drawer idle flag.
	localparam int writeCountWidth = 16;     // completed writes, wraps.
	localparam int writeCountLsb   = 16;     // counter sits in bits 31..16.

endpackage

`default_nettype wire

// File: rtl/instructionDecoder.sv
// instruction decoder: latches an accepted host instruction and splits out its fields.
`timescale 1ns/1ns
`default_nettype none

module instructionDecoder #(
	parameter int memAddrWidth = 12                        // sprite memory address bits.
) (
	input  wire                          clk,
	input  wire                          rstN,
	input  vpuInstrPkg::instrWordT       dataA,            // opcode, index, address.
	input  vpuInstrPkg::instrWordT       dataB,            // operand word.
	input  wire                          instrStrobe,      // one-cycle host pulse.
	input  wire                          busy,             // from execution control.
	output logic                         decodedValid,
	output vpuInstrPkg::opcodeT          opcode,
	output vpuInstrPkg::spriteIdxT       spriteIdx,
	output logic [memAddrWidth-1:0]      memAddr,
	output vpuInstrPkg::instrWordT       operand
);

	logic accept;                                          // strobe taken this cycle.

	// a strobe that arrives while busy is simply lost, the host has to watch busy
	assign accept = instrStrobe & ~busy;

	////////////////////////////////////////
	// valid pulse
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			decodedValid <= 1'b0;                          // nothing pending.
		end else begin
			decodedValid <= accept;                        // high for one cycle.
		end
	end

	////////////////////////////////////////
	// decoded fields
	////////////////////////////////////////

	// fields are held between instructions, no undefined outputs
	always_ff @(posedge clk) begin
		if (accept) begin
			opcode    <= vpuInstrPkg::opcodeT'(
				dataA[vpuInstrPkg::opcodeLsb +: 2]);       // two-bit opcode.
			spriteIdx <= dataA[vpuInstrPkg::spriteIdxLsb +: 5]; // register index.
			memAddr   <= dataA[vpuInstrPkg::memAddrLsb +: memAddrWidth]; // pixel address.
			operand   <= dataB;                            // passed whole, sliced downstream.
		end
	end

endmodule

`default_nettype wire

// File: rtl/executionControl.sv
// execution control: turns decoded instructions into write enables, busy and status replies.
`timescale 1ns/1ns
`default_nettype none

module executionControl (
	input  wire                          clk,
	input  wire                          rstN,
	input  wire                          decodedValid,     // from the decoder.
	input  vpuInstrPkg::opcodeT          opcode,
	input  wire                          drawerIdle,       // from drawing engine.
	output logic                         busy,
	output logic                         posWrite,
	output logic                         offsetWrite,
	output logic                         memWrite,
	output logic                         statusValid,
	output vpuSpritePkg::statusT         statusData
);

	vpuInstrPkg::ctrlStateT                    state;      // current state.
	vpuInstrPkg::ctrlStateT                    stateNext;  // next state.
	logic [vpuSpritePkg::writeCountWidth-1:0]  writeCount; // completed writes.
	logic                                      isWrite;    // any of opcodes 0..2.

	////////////////////////////////////////
	// execute cycle decode
	////////////////////////////////////////

	assign posWrite    = decodedValid & (opcode == vpuInstrPkg::opSetPosition);
	assign memWrite    = decodedValid & (opcode == vpuInstrPkg::opWriteMemory);
	assign offsetWrite = decodedValid & (opcode == vpuInstrPkg::opSetOffset);
	assign statusValid = decodedValid & (opcode == vpuInstrPkg::opReadStatus);
	assign isWrite     = posWrite | memWrite | offsetWrite;

	// busy covers the execute cycle and the settle cycle after it
	assign busy = decodedValid | (state == vpuInstrPkg::ctrlSettle);

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_comb begin
		stateNext = state;                                 // hold by default.
		case (state)
			vpuInstrPkg::ctrlIdle: begin
				if (decodedValid) begin
					stateNext = vpuInstrPkg::ctrlSettle;   // one gap cycle.
				end
			end
			vpuInstrPkg::ctrlSettle: begin
				stateNext = vpuInstrPkg::ctrlIdle;         // ready again.
			end
			default: begin
				stateNext = vpuInstrPkg::ctrlIdle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= vpuInstrPkg::ctrlIdle;
		end else begin
			state <= stateNext;
		end
	end

	////////////////////////////////////////
	// write counter and status word
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			writeCount <= '0;
		end else if (isWrite) begin
			writeCount <= writeCount + 1'b1;               // wraps at 65536.
		end
	end

	// a read sees the count from before its own execute edge
	always_comb begin
		statusData = '0;                                   // unused bits stay zero.
		statusData[vpuSpritePkg::statusIdleBit] = drawerIdle;
		statusData[vpuSpritePkg::writeCountLsb +: vpuSpritePkg::writeCountWidth] = writeCount;
	end

endmodule

`default_nettype wire

// File: rtl/spriteRegisterBank.sv
// sprite register bank: 32 entries of position and memory offset with a drawer read port.
`timescale 1ns/1ns
`default_nettype none

module spriteRegisterBank (
	input  wire                          clk,
	input  wire                          rstN,
	input  vpuInstrPkg::spriteIdxT       spriteIdx,        // write index.
	input  vpuInstrPkg::instrWordT       operand,          // dataB of the instruction.
	input  wire                          posWrite,
	input  wire                          offsetWrite,
	input  vpuInstrPkg::spriteIdxT       spriteReadIdx,    // drawer read index.
	output vpuSpritePkg::coordT          spriteX,
	output vpuSpritePkg::coordT          spriteY,
	output vpuSpritePkg::offsetT         spriteOffset
);

	localparam int numSprites = 32;                        // one per index value.

	vpuSpritePkg::coordT  posX [numSprites];               // x per sprite.
	vpuSpritePkg::coordT  posY [numSprites];               // y per sprite.
	vpuSpritePkg::offsetT offs [numSprites];               // memory offset per sprite.

	vpuSpritePkg::coordT  newX;                            // operand slices.
	vpuSpritePkg::coordT  newY;
	vpuSpritePkg::offsetT newOffset;

	////////////////////////////////////////
	// operand fields
	////////////////////////////////////////

	assign newX      = operand[vpuSpritePkg::coordXLsb +: 10];
	assign newY      = operand[vpuSpritePkg::coordYLsb +: 10];
	assign newOffset = operand[8:0];                       // offset in low 9 bits.

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < numSprites; i++) begin
				posX[i] <= '0;                             // sprite parked at origin.
				posY[i] <= '0;
				offs[i] <= '0;
			end
		end else begin
			if (posWrite) begin
				posX[spriteIdx] <= newX;
				posY[spriteIdx] <= newY;
			end
			if (offsetWrite) begin
				offs[spriteIdx] <= newOffset;              // position untouched.
			end
		end
	end

	// drawer read, no register stage
	assign spriteX      = posX[spriteReadIdx];
	assign spriteY      = posY[spriteReadIdx];
	assign spriteOffset = offs[spriteReadIdx];

endmodule

`default_nettype wire

// File: rtl/spriteMemory.sv
// sprite pixel memory: host colour writes and a registered drawer read.
`timescale 1ns/1ns
`default_nettype none

module spriteMemory #(
	parameter int memAddrWidth = 12                        // 2**memAddrWidth pixels.
) (
	input  wire                          clk,
	input  wire [memAddrWidth-1:0]       memAddr,          // host write address.
	input  vpuInstrPkg::instrWordT       operand,          // colour in bits 8..0.
	input  wire                          memWrite,
	input  wire [memAddrWidth-1:0]       memReadAddr,      // drawer read address.
	output vpuSpritePkg::colorT          memReadData
);

	localparam int memDepth = 2 ** memAddrWidth;           // word count.

	vpuSpritePkg::colorT mem [memDepth];                   // pixel store.
	vpuSpritePkg::colorT writeColor;                       // colour slice.

	assign writeColor = operand[8:0];

	////////////////////////////////////////
	// write and read ports
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (memWrite) begin
			mem[memAddr] <= writeColor;                    // host side.
		end
	end

	// read data appears one cycle after the address
	always_ff @(posedge clk) begin
		memReadData <= mem[memReadAddr];
	end

endmodule

`default_nettype wire

// File: rtl/videoCommandUnit.sv
// video command unit: host instruction front end tying decoder, control and sprite state.
`timescale 1ns/1ns
`default_nettype none

module videoCommandUnit #(
	parameter int memAddrWidth = 12                        // sprite memory address bits.
) (
	input  wire                          clk,
	input  wire                          rstN,
	input  vpuInstrPkg::instrWordT       dataA,
	input  vpuInstrPkg::instrWordT       dataB,
	input  wire                          instrStrobe,
	input  wire                          drawerIdle,
	output logic                         busy,
	output logic                         statusValid,
	output vpuSpritePkg::statusT         statusData,
	input  vpuInstrPkg::spriteIdxT       spriteReadIdx,
	output vpuSpritePkg::coordT          spriteX,
	output vpuSpritePkg::coordT          spriteY,
	output vpuSpritePkg::offsetT         spriteOffset,
	input  wire [memAddrWidth-1:0]       memReadAddr,
	output vpuSpritePkg::colorT          memReadData
);

	logic                          decodedValid;           // decoder to control.
	vpuInstrPkg::opcodeT           opcode;
	vpuInstrPkg::spriteIdxT        spriteIdx;              // decoder to bank.
	logic [memAddrWidth-1:0]       memAddr;                // decoder to memory.
	vpuInstrPkg::instrWordT        operand;
	logic                          posWrite;               // control to bank.
	logic                          offsetWrite;
	logic                          memWrite;               // control to memory.

	////////////////////////////////////////
	// command path
	////////////////////////////////////////

	instructionDecoder #(
		.memAddrWidth (memAddrWidth)
	) decoder0 (
		.clk          (clk),
		.rstN         (rstN),
		.dataA        (dataA),
		.dataB        (dataB),
		.instrStrobe  (instrStrobe),
		.busy         (busy),
		.decodedValid (decodedValid),
		.opcode       (opcode),
		.spriteIdx    (spriteIdx),
		.memAddr      (memAddr),
		.operand      (operand)
	);

	executionControl control0 (
		.clk          (clk),
		.rstN         (rstN),
		.decodedValid (decodedValid),
		.opcode       (opcode),
		.drawerIdle   (drawerIdle),
		.busy         (busy),
		.posWrite     (posWrite),
		.offsetWrite  (offsetWrite),
		.memWrite     (memWrite),
		.statusValid  (statusValid),
		.statusData   (statusData)
	);

	////////////////////////////////////////
	// sprite state
	////////////////////////////////////////

	spriteRegisterBank bank0 (
		.clk           (clk),
		.rstN          (rstN),
		.spriteIdx     (spriteIdx),
		.operand       (operand),
		.posWrite      (posWrite),
		.offsetWrite   (offsetWrite),
		.spriteReadIdx (spriteReadIdx),
		.spriteX       (spriteX),
		.spriteY       (spriteY),
		.spriteOffset  (spriteOffset)
	);

	spriteMemory #(
		.memAddrWidth (memAddrWidth)
	) memory0 (
		.clk          (clk),
		.memAddr      (memAddr),
		.operand      (operand),
		.memWrite     (memWrite),
		.memReadAddr  (memReadAddr),
		.memReadData  (memReadData)
	);

endmodule

`default_nettype wire

// File: verification/videoCommandUnitTb.sv
// directed testbench for the video command unit covering decode, sprite writes, memory and status.
`timescale 1ns/1ns
`default_nettype none

module videoCommandUnitTb;

	localparam int memAddrWidth = 12;                      // matches the top level default.
	localparam int waitLimit    = 50;                      // cycles before a wait gives up.

	logic                         clk = 1'b0;
	logic                         rstN;
	vpuInstrPkg::instrWordT       dataA;
	vpuInstrPkg::instrWordT       dataB;
	logic                         instrStrobe;
	logic                         drawerIdle;
	logic                         busy;
	logic                         statusValid;
	vpuSpritePkg::statusT         statusData;
	vpuInstrPkg::spriteIdxT       spriteReadIdx;
	vpuSpritePkg::coordT          spriteX;
	vpuSpritePkg::coordT          spriteY;
	vpuSpritePkg::offsetT         spriteOffset;
	logic [memAddrWidth-1:0]      memReadAddr;
	vpuSpritePkg::colorT          memReadData;

	logic [31:0]                  lcgState = 32'hef38;     // random stream state.
	int                           testErrors;              // errors in the running test.
	int                           testsPassed;
	int                           testsFailed;
	int                           writesIssued;            // accepted write instructions.
	vpuSpritePkg::coordT          expX [32];               // register bank model.
	vpuSpritePkg::coordT          expY [32];
	vpuSpritePkg::offsetT         expOff [32];
	vpuSpritePkg::colorT          memModel [2**memAddrWidth]; // pixel memory model.

	videoCommandUnit #(
		.memAddrWidth (memAddrWidth)
	) dut0 (
		.clk           (clk),
		.rstN          (rstN),
		.dataA         (dataA),
		.dataB         (dataB),
		.instrStrobe   (instrStrobe),
		.drawerIdle    (drawerIdle),
		.busy          (busy),
		.statusValid   (statusValid),
		.statusData    (statusData),
		.spriteReadIdx (spriteReadIdx),
		.spriteX       (spriteX),
		.spriteY       (spriteY),
		.spriteOffset  (spriteOffset),
		.memReadAddr   (memReadAddr),
		.memReadData   (memReadData)
	);

	always #10 clk = ~clk;                                 // 20 ns period.

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return {lcgState[7:0], lcgState[31:8]};            // high bits are the better ones.
	endfunction

	// index or address sits at bit 4 and the opcode in bits 1..0
	function automatic vpuInstrPkg::instrWordT makeDataA(vpuInstrPkg::opcodeT op,
			logic [17:0] field);
		return {10'b0, field, 2'b0, op};
	endfunction

	task automatic checkCoord(string what, vpuSpritePkg::coordT got, vpuSpritePkg::coordT exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkOffset(string what, vpuSpritePkg::offsetT got,
			vpuSpritePkg::offsetT exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkColor(string what, vpuSpritePkg::colorT got, vpuSpritePkg::colorT exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkStatus(string what, vpuSpritePkg::statusT got,
			vpuSpritePkg::statusT exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkFlag(string what, logic got, logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			testErrors++;
		end
	endtask

	task automatic waitIdle();
		int cycles;
		cycles = 0;
		while (busy !== 1'b0 && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (busy !== 1'b0) begin
			$display("Timed out at %0t ns waiting for busy to go low.", $time);
			testErrors++;
		end
	endtask

	task automatic sendInstruction(vpuInstrPkg::opcodeT op, logic [17:0] field,
			vpuInstrPkg::instrWordT b);
		waitIdle();
		dataA       = makeDataA(op, field);
		dataB       = b;
		instrStrobe = 1'b1;
		@(negedge clk);
		instrStrobe = 1'b0;                                // one-cycle pulse.
		if (op != vpuInstrPkg::opReadStatus) begin
			writesIssued++;
		end
	endtask

	// the read port is combinational and is sampled one falling edge after the index is set
	task automatic checkSprite(vpuInstrPkg::spriteIdxT idx);
		spriteReadIdx = idx;
		@(negedge clk);
		checkCoord($sformatf("x of sprite %0d", idx), spriteX, expX[idx]);
		checkCoord($sformatf("y of sprite %0d", idx), spriteY, expY[idx]);
		checkOffset($sformatf("offset of sprite %0d", idx), spriteOffset, expOff[idx]);
	endtask

	task automatic readStatus(logic idle);
		vpuSpritePkg::statusT expected;
		int cycles;
		drawerIdle = idle;
		expected   = {writesIssued[15:0], 15'b0, idle};   // count from before this read.
		sendInstruction(vpuInstrPkg::opReadStatus, 18'd0, 32'd0);
		cycles = 0;
		while (statusValid !== 1'b1 && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (statusValid !== 1'b1) begin
			$display("Timed out at %0t ns waiting for statusValid.", $time);
			testErrors++;
		end else begin
			checkStatus("status word", statusData, expected);
			@(negedge clk);
			checkFlag("statusValid one cycle later", statusValid, 1'b0);
		end
	endtask

	task automatic finishTest(string name);
		if (testErrors == 0) begin
			$display("test %s: passed", name);
			testsPassed++;
		end else begin
			$display("test %s: failed with %0d errors", name, testErrors);
			testsFailed++;
		end
		testErrors = 0;
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic testReset();
		checkFlag("busy after reset", busy, 1'b0);
		checkFlag("statusValid after reset", statusValid, 1'b0);
		for (int i = 0; i < 32; i++) begin
			checkSprite(5'(i));                            // all zero.
		end
		finishTest("reset");
	endtask

	task automatic testSetPosition();
		vpuInstrPkg::spriteIdxT idx;
		vpuInstrPkg::instrWordT b;
		for (int n = 0; n < 8; n++) begin
			idx = 5'(nextRandom());
			b   = nextRandom();
			sendInstruction(vpuInstrPkg::opSetPosition, 18'(idx), b);
			expX[idx] = b[9:0];
			expY[idx] = b[19:10];
			waitIdle();
			checkSprite(idx);
		end
		for (int i = 0; i < 32; i++) begin
			checkSprite(5'(i));                            // others untouched.
		end
		finishTest("set position");
	endtask

	task automatic testSetOffset();
		vpuInstrPkg::spriteIdxT idx;
		vpuInstrPkg::instrWordT b;
		for (int n = 0; n < 6; n++) begin
			idx = 5'(nextRandom());
			b   = nextRandom();
			sendInstruction(vpuInstrPkg::opSetOffset, 18'(idx), b);
			expOff[idx] = b[8:0];
			waitIdle();
			checkSprite(idx);                              // position kept.
		end
		finishTest("set offset");
	endtask

	task automatic testMemory();
		logic [memAddrWidth-1:0] addr;
		logic [memAddrWidth-1:0] written [$];
		vpuInstrPkg::instrWordT  b;
		for (int n = 0; n < 12; n++) begin
			addr = memAddrWidth'(nextRandom());
			b    = nextRandom();
			sendInstruction(vpuInstrPkg::opWriteMemory, 18'(addr), b);
			memModel[addr] = b[8:0];
			written.push_back(addr);
		end
		waitIdle();
		foreach (written[i]) begin
			memReadAddr = written[i];
			@(negedge clk);                                // registered read.
			checkColor($sformatf("colour at %h", written[i]), memReadData,
				memModel[written[i]]);
		end
		finishTest("memory");
	endtask

	task automatic testStatus();
		readStatus(1'b0);
		readStatus(1'b1);
		finishTest("status");
	endtask

	// the strobe stays high through the execute and settle cycles of the first write
	task automatic testDroppedStrobe();
		vpuInstrPkg::spriteIdxT idx;
		vpuInstrPkg::instrWordT first;
		vpuInstrPkg::instrWordT second;
		idx    = 5'(nextRandom());
		first  = nextRandom();
		second = nextRandom();
		waitIdle();
		dataA       = makeDataA(vpuInstrPkg::opSetPosition, 18'(idx));
		dataB       = first;
		instrStrobe = 1'b1;
		@(negedge clk);
		checkFlag("busy in the execute cycle", busy, 1'b1);
		dataB = second;                                    // strobe still high.
		@(negedge clk);
		checkFlag("busy in the settle cycle", busy, 1'b1);
		@(negedge clk);
		instrStrobe = 1'b0;
		writesIssued++;                                    // only the first counts.
		expX[idx] = first[9:0];
		expY[idx] = first[19:10];
		waitIdle();
		checkSprite(idx);
		readStatus(1'b1);
		finishTest("dropped strobe");
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		rstN          = 1'b0;
		dataA         = '0;
		dataB         = '0;
		instrStrobe   = 1'b0;
		drawerIdle    = 1'b0;
		spriteReadIdx = '0;
		memReadAddr   = '0;
		testErrors    = 0;
		testsPassed   = 0;
		testsFailed   = 0;
		writesIssued  = 0;
		for (int i = 0; i < 32; i++) begin
			expX[i]   = '0;
			expY[i]   = '0;
			expOff[i] = '0;
		end
		repeat (8) @(negedge clk);                         // eight reset cycles.
		rstN = 1'b1;
		@(negedge clk);
		testReset();
		testSetPosition();
		testSetOffset();
		testMemory();
		testStatus();
		testDroppedStrobe();
		$display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/vpuInstrPkg.sv
rtl/vpuSpritePkg.sv
rtl/instructionDecoder.sv
rtl/executionControl.sv
rtl/spriteRegisterBank.sv
rtl/spriteMemory.sv
rtl/videoCommandUnit.sv
verification/videoCommandUnitTb.sv

// File: Bender.yml
package:
  name: video_command_unit

sources:
  # packages first, then the design from leaves to top
  - rtl/vpuInstrPkg.sv
  - rtl/vpuSpritePkg.sv
  - rtl/instructionDecoder.sv
  - rtl/executionControl.sv
  - rtl/spriteRegisterBank.sv
  - rtl/spriteMemory.sv
  - rtl/videoCommandUnit.sv

  - target: simulation
    files:
      - verification/videoCommandUnitTb.sv
